// File: fast_read_top.f
source/fast_read_pkg.sv
source/pkt_sequencer.sv
source/bank_select.sv
source/sample_serializer.sv
source/fast_read_top.sv
test/fast_read_chk.sv
test/fast_read_tb.sv

// File: test/fast_read_tb.sv
`timescale 1ns/1ps

module fast_read_tb
    import fast_read_pkg::*;
();

    localparam int ADDR_W      = 6;
    localparam int RUN_TIMEOUT = 20000;

    logic                             clk = 1'b0;
    logic                             rstn;
    pkt_len_e                         rf_pkt_data_length;
    logic [IDLE_W-1:0]                rf_pkt_idle_length;
    logic                             data_rd_en;
    logic                             fast_read_en;
    logic [NUM_BANKS-1:0][WORD_W-1:0] fast_din;
    logic [NUM_BANKS-1:0]             fast_chip_en;
    logic [ADDR_W-1:0]                fast_addr;
    logic [SAMPLE_W-1:0]              adc_data;
    logic                             adc_data_valid;
    logic                             fast_rd_done;

    int                  seed = 32'h1992_0da2;
    bit                  stall_mode;
    bit                  en_q;
    bit                  run_active;
    bit                  done_seen;
    bit                  timed_out;
    logic [SAMPLE_W-1:0] exp_q[$];
    int                  errors;
    int                  tests_run;
    int                  tests_failed;
    int                  sample_cnt;
    int                  gap_run;
    int                  gap_total;
    int                  idle_exp;

    always #4 clk = ~clk;

    fast_read_top #(
        .ADDR_W (ADDR_W)
    ) uut (
        .clk                (clk),
        .rstn               (rstn),
        .rf_pkt_data_length (rf_pkt_data_length),
        .rf_pkt_idle_length (rf_pkt_idle_length),
        .data_rd_en         (data_rd_en),
        .fast_read_en       (fast_read_en),
        .fast_din           (fast_din),
        .fast_chip_en       (fast_chip_en),
        .fast_addr          (fast_addr),
        .adc_data           (adc_data),
        .adc_data_valid     (adc_data_valid),
        .fast_rd_done       (fast_rd_done)
    );

    // High half tags bank and address, low half is its inverse
    function automatic logic [WORD_W-1:0] mem_word(input int bank, input int addr);
        logic [SAMPLE_W-1:0] hi;
        hi = SAMPLE_W'({bank[4:0], addr[ADDR_W-1:0]});
        return {hi, ~hi};
    endfunction

    // ------------------------------
    // Memory model
    // ------------------------------
    always @(posedge clk) begin
        if (data_rd_en) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (fast_chip_en[b]) begin
                    fast_din[b] <= mem_word(b, fast_addr);
                end
            end
        end
    end

    // ------------------------------
    // Scoreboard
    // ------------------------------
    // Outputs seen here were updated by the previous enabled edge
    always @(posedge clk) begin : monitor
        logic [SAMPLE_W-1:0] exp;
        bit                  last;
        if (en_q && adc_data_valid) begin
            if (gap_run > 0) begin
                assert (gap_run == idle_exp) else begin
                    $display("Fail %0t: gap of %0d enabled cycles, expected %0d",
                             $time, gap_run, idle_exp);
                    errors++;
                end
                gap_run = 0;
            end
            assert (exp_q.size() > 0) else begin
                $display("Fail %0t: extra sample %h after the run", $time, adc_data);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp  = exp_q.pop_front();
                last = (exp_q.size() == 0);
                assert (adc_data == exp) else begin
                    $display("Fail %0t: sample %0d is %h, expected %h",
                             $time, sample_cnt, adc_data, exp);
                    errors++;
                end
                assert (fast_rd_done == last) else begin
                    $display("Fail %0t: fast_rd_done is %b on sample %0d",
                             $time, fast_rd_done, sample_cnt);
                    errors++;
                end
                sample_cnt++;
                run_active = !last;
            end
            if (fast_rd_done) begin
                done_seen = 1'b1;
            end
        end else if (en_q && run_active) begin
            gap_run++;
            gap_total++;
        end
        en_q = data_rd_en;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic drive_enable();
        int r;
        r = $random(seed);
        data_rd_en = stall_mode ? (r[1:0] != 2'b00) : 1'b1;
    endtask

    task automatic build_expected(input pkt_len_e mode);
        int k;
        logic [WORD_W-1:0] w;
        k = 1 << mode;
        exp_q.delete();
        for (int p = 0; p < (1 << ADDR_W) / k; p++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int i = 0; i < k; i++) begin
                    w = mem_word(b, p * k + i);
                    exp_q.push_back(w[WORD_W-1 -: SAMPLE_W]);
                    exp_q.push_back(w[SAMPLE_W-1:0]);
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start && !timed_out) begin
            $display("Test %s: ok, %0d samples", name, sample_cnt);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic check_quiet_after_reset();
        int err_start;
        err_start  = errors;
        stall_mode = 1'b0;
        repeat (12) begin
            @(negedge clk);
            drive_enable();
            assert (fast_chip_en == '0 && !adc_data_valid && !fast_rd_done) else begin
                $display("Fail %0t: output activity before any read request", $time);
                errors++;
            end
        end
        report_test("reset_quiet", err_start);
    endtask

    task automatic run_test(input string name, input pkt_len_e mode, input int idle,
                            input bit stall, input bit busy_pulse);
        int err_start;
        int exp_total;
        int packets;
        int cycles;
        bit pulsed;
        err_start  = errors;
        build_expected(mode);
        exp_total  = exp_q.size();
        packets    = (1 << ADDR_W) >> mode;
        idle_exp   = idle;
        sample_cnt = 0;
        gap_run    = 0;
        gap_total  = 0;
        run_active = 1'b0;
        done_seen  = 1'b0;
        stall_mode = stall;
        pulsed     = 1'b0;
        // Start pulse always lands on an enabled edge
        @(negedge clk);
        rf_pkt_data_length = mode;
        rf_pkt_idle_length = IDLE_W'(idle);
        data_rd_en         = 1'b1;
        fast_read_en       = 1'b1;
        cycles = 0;
        while (!done_seen && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            drive_enable();
            fast_read_en = 1'b0;
            if (busy_pulse && !pulsed && sample_cnt >= 200) begin
                // Different mode on the ignored request
                rf_pkt_data_length = LEN_1728;
                fast_read_en       = 1'b1;
                pulsed             = 1'b1;
            end
            cycles++;
        end
        if (!done_seen) begin
            $display("Timeout: fast_rd_done never came in test %s", name);
            timed_out = 1'b1;
        end else begin
            repeat (6) begin
                @(negedge clk);
                drive_enable();
            end
            assert (sample_cnt == exp_total) else begin
                $display("Fail %0t: %0d samples, expected %0d", $time, sample_cnt, exp_total);
                errors++;
            end
            assert (gap_total == (packets - 1) * idle) else begin
                $display("Fail %0t: %0d gap cycles in total, expected %0d",
                         $time, gap_total, (packets - 1) * idle);
                errors++;
            end
        end
        report_test(name, err_start);
    endtask

    initial begin
        rstn               = 1'b0;
        data_rd_en         = 1'b0;
        fast_read_en       = 1'b0;
        rf_pkt_data_length = LEN_216;
        rf_pkt_idle_length = '0;
        fast_din           = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        check_quiet_after_reset();
        run_test("len216_idle3", LEN_216, 3, 1'b0, 1'b0);
        if (!timed_out) run_test("len1728_stalls", LEN_1728, 2, 1'b1, 1'b0);
        if (!timed_out) run_test("idle0", LEN_864, 0, 1'b0, 1'b0);
        if (!timed_out) run_test("idle5_stalls", LEN_864, 5, 1'b1, 1'b0);
        if (!timed_out) run_test("busy_request", LEN_864, 1, 1'b0, 1'b1);
        if (!timed_out) run_test("len432_restart", LEN_432, 2, 1'b0, 1'b0);

        $display("Tests run %0d, failed %0d, scoreboard errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, uut.u_chk.err_cnt);
        if (errors == 0 && tests_failed == 0 && !timed_out && uut.u_chk.err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: test/fast_read_chk.sv
`timescale 1ns/1ps

module fast_read_chk
    import fast_read_pkg::*;
(
    input logic                 clk,
    input logic                 rstn,
    input logic [NUM_BANKS-1:0] fast_chip_en,
    input logic                 adc_data_valid,
    input logic                 fast_rd_done
);

    int err_cnt = 0;

    // ------------------------------
    // Bus protocol
    // ------------------------------
    chip_en_onehot: assert property (
        @(posedge clk) disable iff (!rstn) $onehot0(fast_chip_en)
    ) else begin
        err_cnt++;
        $error("More than one chip enable active");
    end

    // Done only rides on a sample
    done_with_valid: assert property (
        @(posedge clk) disable iff (!rstn) fast_rd_done |-> adc_data_valid
    ) else begin
        err_cnt++;
        $error("fast_rd_done high without adc_data_valid");
    end

    quiet_in_reset: assert property (
        @(posedge clk) !rstn |-> (!adc_data_valid && fast_chip_en == '0)
    ) else begin
        err_cnt++;
        $error("Valid or chip enable active during reset");
    end

endmodule

bind fast_read_top fast_read_chk u_chk (
    .clk            (clk),
    .rstn           (rstn),
    .fast_chip_en   (fast_chip_en),
    .adc_data_valid (adc_data_valid),
    .fast_rd_done   (fast_rd_done)
);

// File: source/fast_read_top.sv
`timescale 1ns/1ps

module fast_read_top
    import fast_read_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEF
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  pkt_len_e                         rf_pkt_data_length,
    input  logic [IDLE_W-1:0]                rf_pkt_idle_length,
    input  logic                             data_rd_en,
    input  logic                             fast_read_en,
    input  logic [NUM_BANKS-1:0][WORD_W-1:0] fast_din,
    output logic [NUM_BANKS-1:0]             fast_chip_en,
    output logic [ADDR_W-1:0]                fast_addr,
    output logic [SAMPLE_W-1:0]              adc_data,
    output logic                             adc_data_valid,
    output logic                             fast_rd_done
);

    // Sequencer to bank select
    logic              issue;
    bank_idx_t         issue_bank;
    logic [ADDR_W-1:0] issue_addr;
    logic              issue_last;

    // Bank select to serializer
    logic              rd_pend;
    bank_idx_t         rd_bank;
    logic              rd_last;

    // ------------------------------
    // Stage 1
    // ------------------------------
    pkt_sequencer #(
        .ADDR_W (ADDR_W)
    ) u_pkt_sequencer (
        .clk                (clk),
        .rstn               (rstn),
        .data_rd_en         (data_rd_en),
        .fast_read_en       (fast_read_en),
        .rf_pkt_data_length (rf_pkt_data_length),
        .rf_pkt_idle_length (rf_pkt_idle_length),
        .issue              (issue),
        .issue_bank         (issue_bank),
        .issue_addr         (issue_addr),
        .issue_last         (issue_last)
    );

    // ------------------------------
    // Stage 2
    // ------------------------------
    bank_select #(
        .ADDR_W (ADDR_W)
    ) u_bank_select (
        .clk          (clk),
        .rstn         (rstn),
        .data_rd_en   (data_rd_en),
        .issue        (issue),
        .issue_bank   (issue_bank),
        .issue_addr   (issue_addr),
        .issue_last   (issue_last),
        .fast_chip_en (fast_chip_en),
        .fast_addr    (fast_addr),
        .rd_pend      (rd_pend),
        .rd_bank      (rd_bank),
        .rd_last      (rd_last)
    );

    // Stage 3
    sample_serializer u_sample_serializer (
        .clk            (clk),
        .rstn           (rstn),
        .data_rd_en     (data_rd_en),
        .fast_din       (fast_din),
        .rd_pend        (rd_pend),
        .rd_bank        (rd_bank),
        .rd_last        (rd_last),
        .adc_data       (adc_data),
        .adc_data_valid (adc_data_valid),
        .fast_rd_done   (fast_rd_done)
    );

endmodule

// File: source/sample_serializer.sv
`timescale 1ns/1ps

module sample_serializer
    import fast_read_pkg::*;
(
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             data_rd_en,
    input  logic [NUM_BANKS-1:0][WORD_W-1:0] fast_din,
    input  logic                             rd_pend,
    input  bank_idx_t                        rd_bank,
    input  logic                             rd_last,
    output logic [SAMPLE_W-1:0]              adc_data,
    output logic                             adc_data_valid,
    output logic                             fast_rd_done
);

    logic [WORD_W-1:0]   sel_word;
    logic [SAMPLE_W-1:0] low_q;
    logic                low_pend;
    logic                last_q;

    // Bank mux
    assign sel_word = fast_din[rd_bank];

    // ------------------------------
    // Two samples per word
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            adc_data       <= '0;
            adc_data_valid <= 1'b0;
            fast_rd_done   <= 1'b0;
            low_pend       <= 1'b0;
            last_q         <= 1'b0;
        end else if (data_rd_en) begin
            if (rd_pend) begin
                // High half goes out first
                adc_data       <= sel_word[WORD_W-1 -: SAMPLE_W];
                adc_data_valid <= 1'b1;
                fast_rd_done   <= 1'b0;
                low_pend       <= 1'b1;
                last_q         <= rd_last;
            end else if (low_pend) begin
                adc_data       <= low_q;
                adc_data_valid <= 1'b1;
                fast_rd_done   <= last_q;
                low_pend       <= 1'b0;
            end else begin
                adc_data_valid <= 1'b0;
                fast_rd_done   <= 1'b0;
            end
        end
    end

    // Low half waits one enabled cycle
    always_ff @(posedge clk) begin
        if (data_rd_en && rd_pend) begin
            low_q <= sel_word[SAMPLE_W-1:0];
        end
    end

endmodule

// File: source/bank_select.sv
`timescale 1ns/1ps

module bank_select
    import fast_read_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEF
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 data_rd_en,
    input  logic                 issue,
    input  bank_idx_t            issue_bank,
    input  logic [ADDR_W-1:0]    issue_addr,
    input  logic                 issue_last,
    output logic [NUM_BANKS-1:0] fast_chip_en,
    output logic [ADDR_W-1:0]    fast_addr,
    output logic                 rd_pend,
    output bank_idx_t            rd_bank,
    output logic                 rd_last
);

    // Tags for the cycle the chip enable is on the bus
    logic      pend_q;
    bank_idx_t bank_q;
    logic      last_q;

    // ------------------------------
    // Chip enable and tag pipeline
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fast_chip_en <= '0;
            pend_q       <= 1'b0;
            last_q       <= 1'b0;
            rd_pend      <= 1'b0;
            rd_last      <= 1'b0;
        end else if (data_rd_en) begin
            fast_chip_en <= issue ? (NUM_BANKS'(1) << issue_bank) : '0;
            pend_q       <= issue;
            last_q       <= issue && issue_last;
            // Second stage lines up with the word on fast_din
            rd_pend      <= pend_q;
            rd_last      <= last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (data_rd_en) begin
            if (issue) begin
                fast_addr <= issue_addr;
            end
            bank_q  <= issue_bank;
            rd_bank <= bank_q;
        end
    end

endmodule

// File: source/pkt_sequencer.sv
`timescale 1ns/1ps

module pkt_sequencer
    import fast_read_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEF
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              data_rd_en,
    input  logic              fast_read_en,
    input  pkt_len_e          rf_pkt_data_length,
    input  logic [IDLE_W-1:0] rf_pkt_idle_length,
    output logic              issue,
    output bank_idx_t         issue_bank,
    output logic [ADDR_W-1:0] issue_addr,
    output logic              issue_last
);

    seq_state_e        state;
    pkt_len_e          len_q;
    logic [IDLE_W-1:0] idle_cnt;
    logic              phase;
    bank_idx_t         bank_cnt;
    logic [2:0]        word_cnt;
    logic [ADDR_W-1:0] base_addr;

    logic [3:0]        words_per_bank;
    logic              word_last;
    logic              bank_last;
    logic              pkt_last;
    logic              run_last;
    logic              gap_empty;

    // ------------------------------
    // Position decode
    // ------------------------------
    assign words_per_bank = 4'd1 << len_q;
    assign word_last      = ({1'b0, word_cnt} == (words_per_bank - 4'd1));
    assign bank_last      = (bank_cnt == bank_idx_t'(NUM_BANKS - 1));
    assign pkt_last       = word_last && bank_last;

    // Packet p, word k reads address p*K + k in every bank
    assign issue_addr = base_addr + ADDR_W'(word_cnt);

    // Final word of the run sits at the all-ones address
    assign run_last  = pkt_last && (&issue_addr);
    assign gap_empty = (rf_pkt_idle_length == '0);

    // One word every second enabled cycle
    assign issue      = (state == SEQ_BURST) && !phase;
    assign issue_bank = bank_cnt;
    assign issue_last = issue && run_last;

    // ------------------------------
    // Gap / burst FSM and counters
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= SEQ_IDLE;
            len_q     <= LEN_216;
            idle_cnt  <= '0;
            phase     <= 1'b0;
            bank_cnt  <= '0;
            word_cnt  <= '0;
            base_addr <= '0;
        end else if (data_rd_en) begin
            case (state)
                SEQ_IDLE: begin
                    if (fast_read_en) begin
                        len_q     <= rf_pkt_data_length;
                        phase     <= 1'b0;
                        bank_cnt  <= '0;
                        word_cnt  <= '0;
                        base_addr <= '0;
                        if (gap_empty) begin
                            state <= SEQ_BURST;
                        end else begin
                            idle_cnt <= rf_pkt_idle_length - 1'b1;
                            state    <= SEQ_GAP;
                        end
                    end
                end

                SEQ_GAP: begin
                    if (idle_cnt == '0) begin
                        state <= SEQ_BURST;
                    end else begin
                        idle_cnt <= idle_cnt - 1'b1;
                    end
                end

                SEQ_BURST: begin
                    phase <= ~phase;
                    // Counters step on the second half of each word slot
                    if (phase) begin
                        if (!word_last) begin
                            word_cnt <= word_cnt + 3'd1;
                        end else begin
                            word_cnt <= '0;
                            if (!bank_last) begin
                                bank_cnt <= bank_cnt + 1'b1;
                            end else begin
                                bank_cnt  <= '0;
                                base_addr <= base_addr + ADDR_W'(words_per_bank);
                                if (run_last) begin
                                    state <= SEQ_IDLE;
                                end else if (!gap_empty) begin
                                    idle_cnt <= rf_pkt_idle_length - 1'b1;
                                    state    <= SEQ_GAP;
                                end
                            end
                        end
                    end
                end

                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/fast_read_pkg.sv
package fast_read_pkg;

    // ------------------------------
    // Bank and sample geometry
    // ------------------------------
    localparam int NUM_BANKS  = 24;
    localparam int WORD_W     = 36;
    localparam int SAMPLE_W   = 18;
    localparam int IDLE_W     = 16;
    localparam int ADDR_W_DEF = 15;

    typedef logic [4:0] bank_idx_t;

    // ------------------------------
    // Encodings
    // ------------------------------

    // Words per bank is 1 << mode
    typedef enum logic [1:0] {
        LEN_216  = 2'd0,
        LEN_432  = 2'd1,
        LEN_864  = 2'd2,
        LEN_1728 = 2'd3
    } pkt_len_e;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_GAP   = 2'd1,
        SEQ_BURST = 2'd2
    } seq_state_e;

endpackage
